/* files.f */
logic/lsu_pkg.sv
logic/lsu_agu.sv
logic/lsu_req_queue.sv
logic/lsu_misalign_check.sv
logic/lsu_load_unit.sv
logic/lsu_store_unit.sv
logic/lsu_top.sv
dv/lsu_sva.sv
dv/lsu_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := lsu_tb
FILELIST  := files.f
BUILD_DIR := obj_dir

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The binary exits non-zero on $$fatal, so make fails with it
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* dv/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;
  import lsu_pkg::*;

  localparam int unsigned TIMEOUT_CYCLES = 200;
  localparam logic [31:0] SEED           = 32'h1f78;

  typedef struct packed {
    logic       is_load;
    trans_id_t  id;
    xlen_t      result;
    logic       check_result;
    logic       exc;
    exc_cause_t cause;
  } exp_t;

  logic       clk_i;
  logic       rst_ni;
  logic       issue_valid_i;
  logic       issue_ready_o;
  lsu_op_e    op_i;
  xlen_t      operand_a_i;
  xlen_t      imm_i;
  xlen_t      operand_b_i;
  trans_id_t  trans_id_i;
  logic       mem_req_o;
  logic       mem_we_o;
  paddr_t     mem_addr_o;
  be_t        mem_be_o;
  xlen_t      mem_wdata_o;
  logic       mem_rvalid_i;
  xlen_t      mem_rdata_i;
  logic       load_valid_o;
  trans_id_t  load_trans_id_o;
  xlen_t      load_result_o;
  logic       load_exc_valid_o;
  exc_cause_t load_exc_cause_o;
  logic       store_valid_o;
  trans_id_t  store_trans_id_o;
  xlen_t      store_result_o;
  logic       store_exc_valid_o;
  exc_cause_t store_exc_cause_o;

  // Bus-side memory and the reference copy used for expected values
  logic [7:0]  mem     [65536];
  logic [7:0]  ref_mem [65536];
  exp_t        exp_q   [$];
  trans_id_t   next_id;
  int unsigned req_count       = 0;
  int unsigned exp_req_count   = 0;
  int unsigned rd_wait         = 0;
  xlen_t       rd_word         = '0;
  logic [31:0] lat_state       = SEED;
  logic [31:0] stim_state      = SEED;
  logic        ready_drop_seen = 1'b0;

  lsu_top uut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .issue_valid_i     (issue_valid_i),
    .issue_ready_o     (issue_ready_o),
    .op_i              (op_i),
    .operand_a_i       (operand_a_i),
    .imm_i             (imm_i),
    .operand_b_i       (operand_b_i),
    .trans_id_i        (trans_id_i),
    .mem_req_o         (mem_req_o),
    .mem_we_o          (mem_we_o),
    .mem_addr_o        (mem_addr_o),
    .mem_be_o          (mem_be_o),
    .mem_wdata_o       (mem_wdata_o),
    .mem_rvalid_i      (mem_rvalid_i),
    .mem_rdata_i       (mem_rdata_i),
    .load_valid_o      (load_valid_o),
    .load_trans_id_o   (load_trans_id_o),
    .load_result_o     (load_result_o),
    .load_exc_valid_o  (load_exc_valid_o),
    .load_exc_cause_o  (load_exc_cause_o),
    .store_valid_o     (store_valid_o),
    .store_trans_id_o  (store_trans_id_o),
    .store_result_o    (store_result_o),
    .store_exc_valid_o (store_exc_valid_o),
    .store_exc_cause_o (store_exc_cause_o)
  );

  bind lsu_top lsu_sva i_sva (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .issue_ready_o    (issue_ready_o),
    .mem_req_o        (mem_req_o),
    .mem_we_o         (mem_we_o),
    .mem_rvalid_i     (mem_rvalid_i),
    .load_valid_o     (load_valid_o),
    .load_trans_id_o  (load_trans_id_o),
    .store_valid_o    (store_valid_o),
    .store_trans_id_o (store_trans_id_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Initial contents depend on every address bit
  function automatic logic [7:0] fill_byte(int a);
    return 8'(a ^ (a >> 8) ^ 32'h5a);
  endfunction

  task automatic report_failure(string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_field(string name, logic [31:0] got, logic [31:0] expected);
    assert (got === expected)
      else report_failure($sformatf("mismatch %s: got 0x%08h, expected 0x%08h",
                                    name, got, expected));
  endtask

  // Expected outcome of one operation in issue order
  task automatic predict(lsu_op_e op, xlen_t base, xlen_t imm, xlen_t data);
    exp_t  e;
    xlen_t addr;
    xlen_t word;
    int    size;
    int    idx;
    logic  fault;
    logic  misaligned;
    addr      = base + imm;
    e.is_load = (op == LB) || (op == LBU) || (op == LH) || (op == LHU) || (op == LW);
    if (op == LB || op == LBU || op == SB) begin
      size = 1;
    end else if (op == LH || op == LHU || op == SH) begin
      size = 2;
    end else begin
      size = 4;
    end
    fault      = (addr[31:16] != 16'h0);
    misaligned = (addr[1:0] & 2'(size - 1)) != 2'b00;
    e.id       = next_id;
    e.exc      = fault || misaligned;
    e.cause    = '0;
    if (fault) begin
      e.cause = e.is_load ? CAUSE_LD_ACCESS_FAULT : CAUSE_ST_ACCESS_FAULT;
    end else if (misaligned) begin
      e.cause = e.is_load ? CAUSE_LD_MISALIGNED : CAUSE_ST_MISALIGNED;
    end
    word = '0;
    if (!e.exc) begin
      exp_req_count++;
      for (int i = 0; i < size; i++) begin
        idx = int'(addr[15:0]) + i;
        if (e.is_load) begin
          word[8*i +: 8] = ref_mem[idx];
        end else begin
          ref_mem[idx] = data[8*i +: 8];
        end
      end
    end
    case (op)
      LB:      word = {{24{word[7]}}, word[7:0]};
      LH:      word = {{16{word[15]}}, word[15:0]};
      default: word = word;
    endcase
    e.result       = e.is_load ? word : '0;
    e.check_result = !(e.is_load && e.exc);
    exp_q.push_back(e);
  endtask

  // Drive one operation and hold it until the queue accepts it
  task automatic issue_op(lsu_op_e op, xlen_t base, xlen_t imm, xlen_t data);
    int unsigned waited;
    waited = 0;
    predict(op, base, imm, data);
    issue_valid_i = 1'b1;
    op_i          = op;
    operand_a_i   = base;
    imm_i         = imm;
    operand_b_i   = data;
    trans_id_i    = next_id;
    @(negedge clk_i);
    while (!issue_ready_o) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        report_failure("timeout while waiting for issue_ready_o");
      end else begin
        @(negedge clk_i);
      end
    end
    @(posedge clk_i);
    #1;
    issue_valid_i = 1'b0;
    next_id       = next_id + 1'b1;
  endtask

  task automatic check_result(string path, logic is_load, trans_id_t id, xlen_t result,
                              logic exc, exc_cause_t cause);
    exp_t e;
    assert (exp_q.size() != 0)
      else report_failure($sformatf("%s result with no operation outstanding", path));
    e = exp_q.pop_front();
    assert (e.is_load == is_load)
      else report_failure($sformatf("%s result out of issue order, id %0d", path, id));
    check_field({path, "_trans_id_o"}, 32'(id), 32'(e.id));
    check_field({path, "_exc_valid_o"}, 32'(exc), 32'(e.exc));
    if (e.exc) begin
      check_field({path, "_exc_cause_o"}, 32'(cause), 32'(e.cause));
    end
    if (e.check_result) begin
      check_field({path, "_result_o"}, result, e.result);
    end
  endtask

  // --------------------------------------------------------------------------
  // Memory model with reads answered after 1 to 4 cycles
  // --------------------------------------------------------------------------
  initial begin : memory_model
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    for (int a = 0; a < 65536; a++) begin
      mem[a] = fill_byte(a);
    end
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        if (!issue_ready_o && rd_wait != 0) begin
          ready_drop_seen = 1'b1;
        end
        if (mem_req_o) begin
          req_count++;
          check_field("mem_addr_o[1:0]", 32'(mem_addr_o[1:0]), 32'h0);
          if (mem_we_o) begin
            for (int i = 0; i < 4; i++) begin
              if (mem_be_o[i]) begin
                mem[{mem_addr_o[15:2], 2'(i)}] = mem_wdata_o[8*i +: 8];
              end
            end
          end else begin
            assert (rd_wait == 0)
              else report_failure("read request while another read is outstanding");
            for (int i = 0; i < 4; i++) begin
              rd_word[8*i +: 8] = mem[{mem_addr_o[15:2], 2'(i)}];
            end
            lat_state = xorshift32(lat_state);
            rd_wait   = 1 + int'(lat_state[1:0]);
          end
        end
      end
      @(posedge clk_i);
      #1;
      mem_rvalid_i = 1'b0;
      if (rd_wait != 0) begin
        rd_wait--;
        if (rd_wait == 0) begin
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = rd_word;
        end
      end
    end
  end

  // Result strobes are registered and stable at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni && load_valid_o) begin
      check_result("load", 1'b1, load_trans_id_o, load_result_o,
                   load_exc_valid_o, load_exc_cause_o);
    end
    if (rst_ni && store_valid_o) begin
      check_result("store", 1'b0, store_trans_id_o, store_result_o,
                   store_exc_valid_o, store_exc_cause_o);
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin : stimulus
    lsu_op_e     op;
    logic [31:0] r;
    xlen_t       imm;
    xlen_t       base;
    int unsigned waited;
    rst_ni        = 1'b0;
    issue_valid_i = 1'b0;
    op_i          = LB;
    operand_a_i   = '0;
    imm_i         = '0;
    operand_b_i   = '0;
    trans_id_i    = '0;
    next_id       = '0;
    for (int a = 0; a < 65536; a++) begin
      ref_mem[a] = fill_byte(a);
    end
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Stores of each size with a negative offset on the first
    issue_op(SW, 32'h0000_0110, 32'hffff_fff0, 32'hc3a5_96f1);
    issue_op(SH, 32'h0000_0100, 32'h0000_0004, 32'hdead_8a7c);
    issue_op(SH, 32'h0000_0100, 32'h0000_0006, 32'h0000_1234);
    issue_op(SB, 32'h0000_0108, 32'h0000_0000, 32'h0000_0080);
    issue_op(SB, 32'h0000_0108, 32'h0000_0001, 32'h0000_007f);
    issue_op(SB, 32'h0000_0108, 32'h0000_0002, 32'h0000_00fe);
    issue_op(SB, 32'h0000_0108, 32'h0000_0003, 32'h0000_0001);
    // Read back with sign and zero extension
    issue_op(LW,  32'h0000_0100, 32'h0, 32'h0);
    issue_op(LB,  32'h0000_0100, 32'h3, 32'h0);
    issue_op(LBU, 32'h0000_0100, 32'h3, 32'h0);
    issue_op(LH,  32'h0000_0104, 32'h0, 32'h0);
    issue_op(LHU, 32'h0000_0104, 32'h0, 32'h0);
    issue_op(LH,  32'h0000_0104, 32'h2, 32'h0);
    issue_op(LB,  32'h0000_0108, 32'h1, 32'h0);
    issue_op(LB,  32'h0000_0108, 32'h2, 32'h0);
    issue_op(LBU, 32'h0000_0108, 32'h2, 32'h0);
    issue_op(LW,  32'h0000_0108, 32'h0, 32'h0);

    // Misaligned halves and words where stores leave memory alone
    issue_op(LH,  32'h0000_0100, 32'h1, 32'h0);
    issue_op(LHU, 32'h0000_0107, 32'h0, 32'h0);
    issue_op(LW,  32'h0000_0102, 32'h0, 32'h0);
    issue_op(LW,  32'h0000_0100, 32'h1, 32'h0);
    issue_op(SH,  32'h0000_0105, 32'h0, 32'h5555_5555);
    issue_op(SW,  32'h0000_0103, 32'h0, 32'h6666_6666);
    issue_op(SW,  32'h0000_0100, 32'h2, 32'h7777_7777);
    issue_op(LW,  32'h0000_0104, 32'h0, 32'h0);

    // Out of range addresses where the fault wins over misalignment
    issue_op(LW, 32'h0001_0000, 32'h0000_0000, 32'h0);
    issue_op(LB, 32'h0000_0000, 32'hffff_ffff, 32'h0);
    issue_op(LH, 32'h8000_0000, 32'h0000_0001, 32'h0);
    issue_op(SW, 32'h0002_0000, 32'h0000_0003, 32'h1111_2222);
    issue_op(SB, 32'hffff_0100, 32'h0000_0000, 32'h0000_0055);
    issue_op(LW, 32'h0000_0100, 32'h0000_0000, 32'h0);

    // Random mix around 0x300 issued back to back with a few gaps
    for (int n = 0; n < 300; n++) begin
      stim_state = xorshift32(stim_state);
      r          = stim_state;
      op         = lsu_op_e'(r[2:0]);
      imm        = {{24{r[15]}}, r[15:8]};
      if (r[17:16] != 2'b00) begin
        imm[1:0] = 2'b00;
      end
      base = 32'h0000_0300;
      if (r[21:18] == 4'h0) begin
        base = base | (32'h1 << (16 + int'(r[25:22])));
      end
      stim_state = xorshift32(stim_state);
      issue_op(op, base, imm, stim_state);
      if (r[31:29] == 3'b000) begin
        @(posedge clk_i);
        #1;
      end
    end

    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        report_failure("timeout while waiting for outstanding results");
      end else begin
        @(negedge clk_i);
      end
    end
    // Quiet period to catch stray strobes
    repeat (8) @(negedge clk_i);

    check_field("mem_req_o count", req_count, exp_req_count);
    if (!ready_drop_seen) begin
      report_failure("issue_ready_o never dropped while a load was waiting");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

/* dv/lsu_sva.sv */
`timescale 1ns/1ps

module lsu_sva (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               issue_ready_o,
  input logic               mem_req_o,
  input logic               mem_we_o,
  input logic               mem_rvalid_i,
  input logic               load_valid_o,
  input lsu_pkg::trans_id_t load_trans_id_o,
  input logic               store_valid_o,
  input lsu_pkg::trans_id_t store_trans_id_o
);

  logic rd_pending_q;

  // Read outstanding from request until the data strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pending_q <= 1'b0;
    end else if (mem_req_o && !mem_we_o) begin
      rd_pending_q <= 1'b1;
    end else if (mem_rvalid_i) begin
      rd_pending_q <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Protocol properties
  // --------------------------------------------------------------------------
  a_single_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_we_o) |-> !rd_pending_q)
    else $error("read request while a read is outstanding");

  // A strobe lasts one cycle per transaction
  a_load_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_valid_o |=> !load_valid_o || (load_trans_id_o != $past(load_trans_id_o)))
    else $error("load_valid_o held for the same transaction");

  a_store_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_valid_o |=> !store_valid_o || (store_trans_id_o != $past(store_trans_id_o)))
    else $error("store_valid_o held for the same transaction");

  a_reset_idle: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> issue_ready_o && !mem_req_o && !load_valid_o && !store_valid_o)
    else $error("LSU not idle right after reset");

endmodule

/* logic/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Issue side
  input  logic                issue_valid_i,
  output logic                issue_ready_o,
  input  lsu_pkg::lsu_op_e    op_i,
  input  lsu_pkg::xlen_t      operand_a_i,
  input  lsu_pkg::xlen_t      imm_i,
  input  lsu_pkg::xlen_t      operand_b_i,
  input  lsu_pkg::trans_id_t  trans_id_i,
  // Memory side
  output logic                mem_req_o,
  output logic                mem_we_o,
  output lsu_pkg::paddr_t     mem_addr_o,
  output lsu_pkg::be_t        mem_be_o,
  output lsu_pkg::xlen_t      mem_wdata_o,
  input  logic                mem_rvalid_i,
  input  lsu_pkg::xlen_t      mem_rdata_i,
  // Results
  output logic                load_valid_o,
  output lsu_pkg::trans_id_t  load_trans_id_o,
  output lsu_pkg::xlen_t      load_result_o,
  output logic                load_exc_valid_o,
  output lsu_pkg::exc_cause_t load_exc_cause_o,
  output logic                store_valid_o,
  output lsu_pkg::trans_id_t  store_trans_id_o,
  output lsu_pkg::xlen_t      store_result_o,
  output logic                store_exc_valid_o,
  output lsu_pkg::exc_cause_t store_exc_cause_o
);
  import lsu_pkg::*;

  paddr_t     agu_paddr, head_paddr, ld_addr, st_addr;
  be_t        agu_be, head_be, ld_be, st_be;
  logic       agu_overflow, head_overflow, head_valid;
  lsu_op_e    head_op;
  xlen_t      head_wdata, st_wdata;
  trans_id_t  head_trans_id;
  logic       exc_valid;
  exc_cause_t exc_cause;
  logic       ld_valid, st_valid, ld_pop, st_pop, pop;
  logic       ld_req, st_req, ld_busy_q;

  lsu_agu i_agu (
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .imm_i       (imm_i),
    .paddr_o     (agu_paddr),
    .be_o        (agu_be),
    .overflow_o  (agu_overflow)
  );

  lsu_req_queue i_req_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .push_i          (issue_valid_i),
    .op_i            (op_i),
    .paddr_i         (agu_paddr),
    .be_i            (agu_be),
    .overflow_i      (agu_overflow),
    .wdata_i         (operand_b_i),
    .trans_id_i      (trans_id_i),
    .pop_i           (pop),
    .ready_o         (issue_ready_o),
    .head_valid_o    (head_valid),
    .head_op_o       (head_op),
    .head_paddr_o    (head_paddr),
    .head_be_o       (head_be),
    .head_overflow_o (head_overflow),
    .head_wdata_o    (head_wdata),
    .head_trans_id_o (head_trans_id)
  );

  lsu_misalign_check i_misalign_check (
    .valid_i     (head_valid),
    .op_i        (head_op),
    .paddr_i     (head_paddr),
    .overflow_i  (head_overflow),
    .exc_valid_o (exc_valid),
    .exc_cause_o (exc_cause)
  );

  // --------------------------------------------------------------------------
  // Head routing
  // --------------------------------------------------------------------------
  // Read in flight from request until data returns
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ld_busy_q <= 1'b0;
    end else if (ld_req) begin
      ld_busy_q <= 1'b1;
    end else if (mem_rvalid_i) begin
      ld_busy_q <= 1'b0;
    end
  end

  // Stores wait behind an outstanding load to keep results in order
  assign ld_valid = head_valid && op_is_load(head_op);
  assign st_valid = head_valid && !op_is_load(head_op) && !ld_busy_q;
  assign pop      = ld_pop || st_pop;

  lsu_load_unit i_load_unit (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .valid_i          (ld_valid),
    .op_i             (head_op),
    .paddr_i          (head_paddr),
    .be_i             (head_be),
    .trans_id_i       (head_trans_id),
    .exc_valid_i      (exc_valid),
    .exc_cause_i      (exc_cause),
    .mem_rvalid_i     (mem_rvalid_i),
    .mem_rdata_i      (mem_rdata_i),
    .pop_o            (ld_pop),
    .mem_req_o        (ld_req),
    .mem_addr_o       (ld_addr),
    .mem_be_o         (ld_be),
    .load_valid_o     (load_valid_o),
    .load_trans_id_o  (load_trans_id_o),
    .load_result_o    (load_result_o),
    .load_exc_valid_o (load_exc_valid_o),
    .load_exc_cause_o (load_exc_cause_o)
  );

  lsu_store_unit i_store_unit (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .valid_i           (st_valid),
    .paddr_i           (head_paddr),
    .be_i              (head_be),
    .wdata_i           (head_wdata),
    .trans_id_i        (head_trans_id),
    .exc_valid_i       (exc_valid),
    .exc_cause_i       (exc_cause),
    .pop_o             (st_pop),
    .mem_req_o         (st_req),
    .mem_addr_o        (st_addr),
    .mem_be_o          (st_be),
    .mem_wdata_o       (st_wdata),
    .store_valid_o     (store_valid_o),
    .store_trans_id_o  (store_trans_id_o),
    .store_exc_valid_o (store_exc_valid_o),
    .store_exc_cause_o (store_exc_cause_o)
  );

  // --------------------------------------------------------------------------
  // Memory port, one unit strobes at a time
  // --------------------------------------------------------------------------
  assign mem_req_o   = ld_req || st_req;
  assign mem_we_o    = st_req;
  assign mem_addr_o  = st_req ? st_addr : ld_addr;
  assign mem_be_o    = st_req ? st_be : ld_be;
  assign mem_wdata_o = st_wdata;

  // Stores return no data
  assign store_result_o = '0;

endmodule

/* logic/lsu_store_unit.sv */
`timescale 1ns/1ps

module lsu_store_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                valid_i,
  input  lsu_pkg::paddr_t     paddr_i,
  input  lsu_pkg::be_t        be_i,
  input  lsu_pkg::xlen_t      wdata_i,
  input  lsu_pkg::trans_id_t  trans_id_i,
  input  logic                exc_valid_i,
  input  lsu_pkg::exc_cause_t exc_cause_i,
  output logic                pop_o,
  output logic                mem_req_o,
  output lsu_pkg::paddr_t     mem_addr_o,
  output lsu_pkg::be_t        mem_be_o,
  output lsu_pkg::xlen_t      mem_wdata_o,
  output logic                store_valid_o,
  output lsu_pkg::trans_id_t  store_trans_id_o,
  output logic                store_exc_valid_o,
  output lsu_pkg::exc_cause_t store_exc_cause_o
);
  import lsu_pkg::*;

  // Stores never stall once they reach this unit
  assign pop_o     = valid_i;
  assign mem_req_o = valid_i && !exc_valid_i;

  // --------------------------------------------------------------------------
  // Write request
  // --------------------------------------------------------------------------
  assign mem_addr_o = {paddr_i[PADDR_W-1:2], 2'b00};
  assign mem_be_o   = be_i;

  // Move the low bytes up to the addressed lanes
  assign mem_wdata_o = wdata_i << {paddr_i[1:0], 3'b000};

  // Completion stage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      store_valid_o     <= 1'b0;
      store_exc_valid_o <= 1'b0;
    end else begin
      store_valid_o     <= valid_i;
      store_exc_valid_o <= valid_i && exc_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      store_trans_id_o  <= trans_id_i;
      store_exc_cause_o <= exc_cause_i;
    end
  end

endmodule

/* logic/lsu_load_unit.sv */
`timescale 1ns/1ps

module lsu_load_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                valid_i,
  input  lsu_pkg::lsu_op_e    op_i,
  input  lsu_pkg::paddr_t     paddr_i,
  input  lsu_pkg::be_t        be_i,
  input  lsu_pkg::trans_id_t  trans_id_i,
  input  logic                exc_valid_i,
  input  lsu_pkg::exc_cause_t exc_cause_i,
  input  logic                mem_rvalid_i,
  input  lsu_pkg::xlen_t      mem_rdata_i,
  output logic                pop_o,
  output logic                mem_req_o,
  output lsu_pkg::paddr_t     mem_addr_o,
  output lsu_pkg::be_t        mem_be_o,
  output logic                load_valid_o,
  output lsu_pkg::trans_id_t  load_trans_id_o,
  output lsu_pkg::xlen_t      load_result_o,
  output logic                load_exc_valid_o,
  output lsu_pkg::exc_cause_t load_exc_cause_o
);
  import lsu_pkg::*;

  typedef enum logic {
    IDLE,
    WAIT
  } state_e;

  state_e    state_q, state_d;
  lsu_op_e   op_q;
  logic[1:0] offset_q;
  trans_id_t id_q;
  logic      take, done_exc, done_rd;
  xlen_t     shifted, extended;

  assign take     = (state_q == IDLE) && valid_i;
  assign done_exc = take && exc_valid_i;
  assign done_rd  = (state_q == WAIT) && mem_rvalid_i;

  assign pop_o      = take;
  assign mem_req_o  = take && !exc_valid_i;
  assign mem_addr_o = {paddr_i[PADDR_W-1:2], 2'b00};
  assign mem_be_o   = be_i;

  always_comb begin
    state_d = state_q;
    if (mem_req_o) state_d = WAIT;
    if (done_rd)   state_d = IDLE;
  end

  // --------------------------------------------------------------------------
  // Result alignment and extension
  // --------------------------------------------------------------------------
  assign shifted = mem_rdata_i >> {offset_q, 3'b000};

  always_comb begin
    case (op_q)
      LB:      extended = {{24{shifted[7]}}, shifted[7:0]};
      LBU:     extended = {24'h0, shifted[7:0]};
      LH:      extended = {{16{shifted[15]}}, shifted[15:0]};
      LHU:     extended = {16'h0, shifted[15:0]};
      default: extended = shifted;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= IDLE;
      load_valid_o     <= 1'b0;
      load_exc_valid_o <= 1'b0;
    end else begin
      state_q          <= state_d;
      load_valid_o     <= done_exc || done_rd;
      load_exc_valid_o <= done_exc;
    end
  end

  // Request context held across the read, then the result stage
  always_ff @(posedge clk_i) begin
    if (take) begin
      op_q     <= op_i;
      offset_q <= paddr_i[1:0];
      id_q     <= trans_id_i;
    end
    if (done_exc) begin
      load_trans_id_o  <= trans_id_i;
      load_result_o    <= '0;
      load_exc_cause_o <= exc_cause_i;
    end else if (done_rd) begin
      load_trans_id_o  <= id_q;
      load_result_o    <= extended;
      load_exc_cause_o <= '0;
    end
  end

endmodule

/* logic/lsu_misalign_check.sv */
`timescale 1ns/1ps

module lsu_misalign_check (
  input  logic                valid_i,
  input  lsu_pkg::lsu_op_e    op_i,
  input  lsu_pkg::paddr_t     paddr_i,
  input  logic                overflow_i,
  output logic                exc_valid_o,
  output lsu_pkg::exc_cause_t exc_cause_o
);
  import lsu_pkg::*;

  logic misaligned;
  logic is_load;

  assign is_load = op_is_load(op_i);

  // Bytes are always aligned
  always_comb begin
    case (op_i)
      LH, LHU, SH: misaligned = paddr_i[0];
      LW, SW:      misaligned = (paddr_i[1:0] != 2'b00);
      default:     misaligned = 1'b0;
    endcase
  end

  always_comb begin
    exc_valid_o = 1'b0;
    exc_cause_o = '0;
    if (valid_i) begin
      if (misaligned) begin
        exc_valid_o = 1'b1;
        exc_cause_o = is_load ? CAUSE_LD_MISALIGNED : CAUSE_ST_MISALIGNED;
      end
      // Access fault wins over misalignment
      if (overflow_i) begin
        exc_valid_o = 1'b1;
        exc_cause_o = is_load ? CAUSE_LD_ACCESS_FAULT : CAUSE_ST_ACCESS_FAULT;
      end
    end
  end

endmodule

/* logic/lsu_req_queue.sv */
`timescale 1ns/1ps

module lsu_req_queue (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               push_i,
  input  lsu_pkg::lsu_op_e   op_i,
  input  lsu_pkg::paddr_t    paddr_i,
  input  lsu_pkg::be_t       be_i,
  input  logic               overflow_i,
  input  lsu_pkg::xlen_t     wdata_i,
  input  lsu_pkg::trans_id_t trans_id_i,
  input  logic               pop_i,
  output logic               ready_o,
  output logic               head_valid_o,
  output lsu_pkg::lsu_op_e   head_op_o,
  output lsu_pkg::paddr_t    head_paddr_o,
  output lsu_pkg::be_t       head_be_o,
  output logic               head_overflow_o,
  output lsu_pkg::xlen_t     head_wdata_o,
  output lsu_pkg::trans_id_t head_trans_id_o
);
  import lsu_pkg::*;

  lsu_op_e   op_q       [QUEUE_DEPTH];
  paddr_t    paddr_q    [QUEUE_DEPTH];
  be_t       be_q       [QUEUE_DEPTH];
  logic      overflow_q [QUEUE_DEPTH];
  xlen_t     wdata_q    [QUEUE_DEPTH];
  trans_id_t trans_id_q [QUEUE_DEPTH];

  logic [$clog2(QUEUE_DEPTH)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(QUEUE_DEPTH+1)-1:0] count_q;
  logic                             push_en, pop_en;

  assign ready_o      = (count_q != QUEUE_DEPTH);
  assign head_valid_o = (count_q != '0);
  assign push_en      = push_i && ready_o;
  assign pop_en       = pop_i && head_valid_o;

  // --------------------------------------------------------------------------
  // Pointers and fill level
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == QUEUE_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == QUEUE_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      op_q[wr_ptr_q]       <= op_i;
      paddr_q[wr_ptr_q]    <= paddr_i;
      be_q[wr_ptr_q]       <= be_i;
      overflow_q[wr_ptr_q] <= overflow_i;
      wdata_q[wr_ptr_q]    <= wdata_i;
      trans_id_q[wr_ptr_q] <= trans_id_i;
    end
  end

  assign head_op_o       = op_q[rd_ptr_q];
  assign head_paddr_o    = paddr_q[rd_ptr_q];
  assign head_be_o       = be_q[rd_ptr_q];
  assign head_overflow_o = overflow_q[rd_ptr_q];
  assign head_wdata_o    = wdata_q[rd_ptr_q];
  assign head_trans_id_o = trans_id_q[rd_ptr_q];

endmodule

/* logic/lsu_agu.sv */
`timescale 1ns/1ps

module lsu_agu (
  input  lsu_pkg::lsu_op_e op_i,
  input  lsu_pkg::xlen_t   operand_a_i,
  input  lsu_pkg::xlen_t   imm_i,
  output lsu_pkg::paddr_t  paddr_o,
  output lsu_pkg::be_t     be_o,
  output logic             overflow_o
);
  import lsu_pkg::*;

  xlen_t vaddr;

  // Effective address, both operands signed
  assign vaddr = xlen_t'($signed(operand_a_i) + $signed(imm_i));

  // Bare translation keeps the low bits only
  assign paddr_o = vaddr[PADDR_W-1:0];

  // Anything above the physical range is an access fault later on
  assign overflow_o = |vaddr[XLEN-1:PADDR_W];

  // Byte enables from size and offset in the word
  always_comb begin
    case (op_size_bytes(op_i))
      3'd1: begin
        be_o = 4'b0001 << paddr_o[1:0];
      end
      3'd2: begin
        // An odd offset loses a lane, the access traps anyway
        be_o = 4'b0011 << paddr_o[1:0];
      end
      default: begin
        be_o = 4'b1111;
      end
    endcase
  end

endmodule

/* logic/lsu_pkg.sv */
package lsu_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int unsigned XLEN        = 32;
  localparam int unsigned PADDR_W     = 16;
  localparam int unsigned TRANS_ID_W  = 3;
  localparam int unsigned QUEUE_DEPTH = 2;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [PADDR_W-1:0]    paddr_t;
  typedef logic [XLEN/8-1:0]     be_t;
  typedef logic [TRANS_ID_W-1:0] trans_id_t;
  typedef logic [3:0]            exc_cause_t;

  // Load and store operations handled by the LSU
  typedef enum logic [3:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  // --------------------------------------------------------------------------
  // Exception causes
  // --------------------------------------------------------------------------
  localparam exc_cause_t CAUSE_LD_MISALIGNED   = 4'd4;
  localparam exc_cause_t CAUSE_LD_ACCESS_FAULT = 4'd5;
  localparam exc_cause_t CAUSE_ST_MISALIGNED   = 4'd6;
  localparam exc_cause_t CAUSE_ST_ACCESS_FAULT = 4'd7;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic op_is_load(lsu_op_e op);
    case (op)
      LB, LBU, LH, LHU, LW: return 1'b1;
      default:              return 1'b0;
    endcase
  endfunction

  // Transfer size in bytes
  function automatic logic [2:0] op_size_bytes(lsu_op_e op);
    case (op)
      LB, LBU, SB: return 3'd1;
      LH, LHU, SH: return 3'd2;
      default:     return 3'd4;
    endcase
  endfunction

endpackage
